// File: files.f
source/fifo_asym_pkg.sv
source/fifo_bank_ram.sv
source/fifo_write_ctrl.sv
source/fifo_occupancy.sv
source/fifo_read_ctrl.sv
source/fifo_asym_top.sv
test/fifo_asym_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile the FIFO testbench with Verilator and run it.
# The exit status is the simulator's own status.

cd "$(dirname "$0")" || exit 1

TOP=fifo_asym_tb
OBJ_DIR=obj_dir
SIM_BIN=fifo_asym_sim

verilator --binary --timing \
  -f files.f \
  --top-module "$TOP" \
  -Mdir "$OBJ_DIR" \
  -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

"./$OBJ_DIR/$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation run completed"
exit 0

// File: test/fifo_asym_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_asym_tb;

  import fifo_asym_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 16;
  localparam int FILL_CYCLES = 120;
  localparam int MIXED_CYCLES = 400;
  localparam int DRAIN_CYCLES = 150;
  localparam int IDLE_CYCLES = 10;
  localparam int TOTAL_CYCLES = FILL_CYCLES + MIXED_CYCLES + DRAIN_CYCLES + IDLE_CYCLES;
  localparam int WATCHDOG_NS = (2 * TOTAL_CYCLES + RESET_CYCLES) * CLK_PERIOD;

  // Highest level that still leaves one whole row free
  localparam int FULL_MARK = CAPACITY - RATIO;

  logic         clk = 1'b0;
  logic         rst = 1'b1;
  logic         wr_en = 1'b0;
  wide_word_t   wr_data = '0;
  logic         rd_en = 1'b0;
  narrow_word_t rd_data;
  logic         rd_valid;
  logic         empty;
  logic         full;
  level_t       level;

  int seed = 53002;

  // Reference model of narrow words in write order
  narrow_word_t model_q [$];
  int           model_level = 0;
  logic         exp_valid = 1'b0;
  narrow_word_t exp_word = '0;
  logic         wr_ok;
  logic         rd_ok;

  // Event counts used to confirm the stimulus reached each corner
  int read_count = 0;
  int blocked_writes = 0;
  int blocked_reads = 0;
  int both_count = 0;

  fifo_asym_top u_dut (
    .clk      (clk),
    .rst      (rst),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .empty    (empty),
    .full     (full),
    .level    (level)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_with_fail();
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_word(input string name, input narrow_word_t actual,
                            input narrow_word_t expected);
    if (actual !== expected) begin
      $display("error: time %0t, %s is %h, expected %h", $time, name, actual, expected);
      abort_with_fail();
    end
  endtask

  task automatic check_level(input string name, input level_t actual,
                             input level_t expected);
    if (actual !== expected) begin
      $display("error: time %0t, %s is %0d, expected %0d", $time, name, actual, expected);
      abort_with_fail();
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("error: time %0t, %s is %b, expected %b", $time, name, actual, expected);
      abort_with_fail();
    end
  endtask

  // Outputs the DUT shows while reset is held
  task automatic check_reset_state();
    check_level("level", level, '0);
    check_flag("empty", empty, 1'b1);
    check_flag("full", full, 1'b0);
    check_flag("rd_valid", rd_valid, 1'b0);
  endtask

  // Compare every output with the model state after the last rising edge
  task automatic check_outputs();
    check_level("level", level, level_t'(model_level));
    check_flag("empty", empty, model_level == 0);
    check_flag("full", full, model_level > FULL_MARK);
    check_flag("rd_valid", rd_valid, exp_valid);
    if (exp_valid) begin
      check_word("rd_data", rd_data, exp_word);
    end
  endtask

  // Apply the inputs held now as the DUT will see them at the next rising edge
  task automatic advance_model();
    wr_ok = wr_en && (model_level <= FULL_MARK);
    rd_ok = rd_en && (model_level > 0);
    if (wr_en && !wr_ok) begin
      blocked_writes++;
    end
    if (rd_en && !rd_ok) begin
      blocked_reads++;
    end
    if (wr_ok && rd_ok) begin
      both_count++;
    end
    exp_valid = rd_ok;
    if (rd_ok) begin
      exp_word = model_q.pop_front();
      model_level = model_level - 1;
      read_count++;
    end
    if (wr_ok) begin
      // Slice 0 is the low end and leaves first
      for (int k = 0; k < RATIO; k++) begin
        model_q.push_back(wr_data[k*R_DATA_W +: R_DATA_W]);
      end
      model_level = model_level + RATIO;
    end
  endtask

  // Random enables with thresholds in sixteenths
  task automatic drive_phase(input int cycles, input int wr_thr, input int rd_thr);
    int rnd;
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      rnd = $random(seed);
      wr_en <= ((rnd & 15) < wr_thr);
      rd_en <= (((rnd >> 4) & 15) < rd_thr);
      wr_data <= wide_word_t'($random(seed));
    end
  endtask

  // Outputs are settled at the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      check_outputs();
      advance_model();
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run hung", WATCHDOG_NS);
    abort_with_fail();
  end

  initial begin
    repeat (RESET_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check_reset_state();
    @(posedge clk);
    rst <= 1'b0;

    drive_phase(FILL_CYCLES, 14, 2);
    drive_phase(MIXED_CYCLES, 4, 13);
    drive_phase(DRAIN_CYCLES, 1, 15);
    drive_phase(IDLE_CYCLES, 0, 16);

    @(posedge clk);
    wr_en <= 1'b0;
    rd_en <= 1'b0;
    // Let the last read and the checks after it complete
    repeat (3) @(posedge clk);

    if (blocked_writes == 0) begin
      $display("No write was ever issued while the FIFO was full");
      abort_with_fail();
    end else if (blocked_reads == 0) begin
      $display("No read was ever issued while the FIFO was empty");
      abort_with_fail();
    end else if (both_count == 0) begin
      $display("No edge accepted a write and a read together");
      abort_with_fail();
    end else if (read_count < 2 * CAPACITY) begin
      $display("Only %0d reads accepted, too few to wrap the rows", read_count);
      abort_with_fail();
    end else if (model_level != 0) begin
      $display("FIFO still holds %0d words after the idle phase", model_level);
      abort_with_fail();
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: source/fifo_asym_top.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_asym_top (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      wr_en,
  input  wire fifo_asym_pkg::wide_word_t wr_data,
  input  wire logic                      rd_en,
  output fifo_asym_pkg::narrow_word_t    rd_data,
  output logic                           rd_valid,
  output logic                           empty,
  output logic                           full,
  output fifo_asym_pkg::level_t          level
);

  import fifo_asym_pkg::*;

  logic         wr_accept;
  logic         rd_accept;
  bank_wr_t     bank_wr;
  bank_rd_t     bank_rd;

  // Registered read word of every lane
  narrow_word_t bank_data [RATIO];

  fifo_write_ctrl u_write_ctrl (
    .clk       (clk),
    .rst       (rst),
    .wr_en     (wr_en),
    .full      (full),
    .wr_accept (wr_accept),
    .bank_wr   (bank_wr)
  );

  fifo_occupancy u_occupancy (
    .clk       (clk),
    .rst       (rst),
    .wr_accept (wr_accept),
    .rd_accept (rd_accept),
    .level     (level),
    .full      (full),
    .empty     (empty)
  );

  fifo_read_ctrl u_read_ctrl (
    .clk       (clk),
    .rst       (rst),
    .rd_en     (rd_en),
    .empty     (empty),
    .bank_data (bank_data),
    .rd_accept (rd_accept),
    .bank_rd   (bank_rd),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid)
  );

  // One bank per lane; slice 0 is the low end of the wide word
  for (genvar i = 0; i < RATIO; i++) begin : bank
    fifo_bank_ram u_ram (
      .clk     (clk),
      .wr      (bank_wr),
      .wr_data (wr_data[i*R_DATA_W +: R_DATA_W]),
      .rd      (bank_rd),
      .rd_data (bank_data[i])
    );
  end

endmodule

`default_nettype wire

// File: source/fifo_read_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_read_ctrl (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic                        rd_en,
  input  wire logic                        empty,
  input  wire fifo_asym_pkg::narrow_word_t bank_data [fifo_asym_pkg::RATIO],
  output logic                             rd_accept,
  output fifo_asym_pkg::bank_rd_t          bank_rd,
  output fifo_asym_pkg::narrow_word_t      rd_data,
  output logic                             rd_valid
);

  import fifo_asym_pkg::*;

  // Read position as the lane within a row and the row itself
  lane_t     rd_lane;
  lane_t     rd_lane_next;
  row_addr_t rd_row;
  row_addr_t rd_row_next;

  // Lane of the read in flight picks the bank output
  lane_t     sel_lane;
  logic      last_lane;

  assign rd_accept = rd_en & ~empty;

  // Row only moves on once all lanes of it are consumed
  assign last_lane = (rd_lane == lane_t'(RATIO - 1));

  always_comb begin
    rd_lane_next = rd_lane;
    rd_row_next = rd_row;
    if (rd_accept) begin
      // RATIO is a power of two, so the lane wraps by itself
      rd_lane_next = rd_lane + lane_t'(1);
      if (last_lane) begin
        rd_row_next = rd_row + row_addr_t'(1);
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_lane <= '0;
      rd_row <= '0;
    end else begin
      rd_lane <= rd_lane_next;
      rd_row <= rd_row_next;
    end
  end

  // All banks fetch the same row; only one lane is shown
  always_comb begin
    bank_rd.en = rd_accept;
    bank_rd.row = rd_row;
  end

  // Track the read in flight for one cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sel_lane <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_accept;
      if (rd_accept) begin
        sel_lane <= rd_lane;
      end
    end
  end

  // Bank outputs are already registered, so a plain mux is enough
  assign rd_data = bank_data[sel_lane];

endmodule

`default_nettype wire

// File: source/fifo_occupancy.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_occupancy (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire logic             wr_accept,
  input  wire logic             rd_accept,
  output fifo_asym_pkg::level_t level,
  output logic                  full,
  output logic                  empty
);

  import fifo_asym_pkg::*;

  level_t level_next;

  // A wide write adds RATIO narrow words, a read takes one
  always_comb begin
    case ({wr_accept, rd_accept})
      2'b10: level_next = level + level_t'(RATIO);
      2'b01: level_next = level - level_t'(1);
      2'b11: level_next = level + level_t'(RATIO - 1);
      default: level_next = level;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      level <= '0;
    end else begin
      level <= level_next;
    end
  end

  // Full means no complete row left for the next wide word
  assign full = (level > level_t'(CAPACITY - RATIO));
  assign empty = (level == '0);

endmodule

`default_nettype wire

// File: source/fifo_write_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_write_ctrl (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    wr_en,
  input  wire logic                    full,
  output logic                         wr_accept,
  output fifo_asym_pkg::bank_wr_t      bank_wr
);

  import fifo_asym_pkg::*;

  row_addr_t wr_row;
  row_addr_t wr_row_next;

  // A write only lands when a whole row is free
  assign wr_accept = wr_en & ~full;

  // Row pointer wraps at ROWS on its own width
  always_comb begin
    wr_row_next = wr_row;
    if (wr_accept) begin
      wr_row_next = wr_row + row_addr_t'(1);
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_row <= '0;
    end else begin
      wr_row <= wr_row_next;
    end
  end

  // Every bank sees the same enable and row
  always_comb begin
    bank_wr.en = wr_accept;
    bank_wr.row = wr_row;
  end

endmodule

`default_nettype wire

// File: source/fifo_bank_ram.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_bank_ram (
  input  wire logic                       clk,
  input  wire fifo_asym_pkg::bank_wr_t    wr,
  input  wire fifo_asym_pkg::narrow_word_t wr_data,
  input  wire fifo_asym_pkg::bank_rd_t    rd,
  output fifo_asym_pkg::narrow_word_t     rd_data
);

  import fifo_asym_pkg::*;

  // One lane of the FIFO with ROWS narrow words
  narrow_word_t mem [ROWS];

  // Write port
  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.row] <= wr_data;
    end
  end

  // Registered read port that holds its word between reads
  always_ff @(posedge clk) begin
    if (rd.en) begin
      rd_data <= mem[rd.row];
    end
  end

endmodule

`default_nettype wire

// File: source/fifo_asym_pkg.sv
`default_nettype none

package fifo_asym_pkg;

  // Data widths on each side
  localparam int W_DATA_W = 32;
  localparam int R_DATA_W = 8;

  // Narrow words per wide word and the number of banks
  localparam int RATIO = W_DATA_W / R_DATA_W;
  localparam int LANE_W = $clog2(RATIO);

  // Bank geometry
  localparam int ROW_ADDR_W = 4;
  localparam int ROWS = 2 ** ROW_ADDR_W;

  // Total storage counted in narrow words
  localparam int CAPACITY = ROWS * RATIO;
  localparam int LEVEL_W = $clog2(CAPACITY + 1);

  typedef logic [W_DATA_W-1:0] wide_word_t;
  typedef logic [R_DATA_W-1:0] narrow_word_t;
  typedef logic [ROW_ADDR_W-1:0] row_addr_t;
  typedef logic [LANE_W-1:0] lane_t;
  typedef logic [LEVEL_W-1:0] level_t;

  // Write access shared by every bank
  typedef struct packed {
    logic en;
    row_addr_t row;
  } bank_wr_t;

  // Read access shared by every bank
  typedef struct packed {
    logic en;
    row_addr_t row;
  } bank_rd_t;

endpackage

`default_nettype wire
